//--- design/fp_add_cfg.svh
`ifndef FP_ADD_CFG_SVH
`define FP_ADD_CFG_SVH

// IEEE 754 double precision word layout

// Full word width
`define FP_WORD_SIZE 64

// Stored fraction bits, hidden one not counted
`define FP_MANTISSA_SIZE 52

// Biased exponent field
`define FP_EXPONENT_SIZE 11

// Exponent bias of the format
`define FP_EXP_BIAS 1023

// All-ones exponent, reserved for infinity
`define FP_EXP_MAX 2047

// Normalization shift count width
// Must hold FP_MANTISSA_SIZE + 1
`define FP_SHIFT_MAX 7

`endif

//--- design/fp_add_pkg.sv
`include "fp_add_cfg.svh"

package fp_add_pkg;

  // Packed double word
  // Bit 63 sign, 62..52 exponent, 51..0 fraction
  typedef logic [`FP_WORD_SIZE-1:0] fp_word_t;

  // Biased exponent, unsigned
  typedef logic [`FP_EXPONENT_SIZE-1:0] exp_t;

  // Extended mantissa
  // Top bit catches the carry of an addition
  // Next bit is the hidden one
  // Low bits are the stored fraction
  typedef logic [`FP_MANTISSA_SIZE+1:0] mant_t;

  // Normalization shift count
  // Holds 0 to FP_MANTISSA_SIZE + 1
  typedef logic [`FP_SHIFT_MAX-1:0] shift_t;

endpackage

//--- design/shift_amount.sv
`timescale 1ns/1ps

module shift_amount #(
  parameter int MANTISSA_SIZE = 52,
  parameter int SHIFT_MAX     = 7
) (
  input  logic [MANTISSA_SIZE+1:0] a,
  input  logic                     add,
  output logic [SHIFT_MAX-1:0]     shift
);

  // Count for a sum with no one at all
  localparam logic [SHIFT_MAX-1:0] NO_ONE = SHIFT_MAX'(MANTISSA_SIZE + 1);
  localparam logic [SHIFT_MAX-1:0] SHIFT_ONE = SHIFT_MAX'(1);
  localparam logic [SHIFT_MAX-1:0] SHIFT_NONE = '0;

  // Effective addition count
  logic [SHIFT_MAX-1:0] add_shift;
  // Effective subtraction count
  logic [SHIFT_MAX-1:0] lead_shift;
  // Scan has hit the first one
  logic                 found;

  // Addition only ever needs one step right
  // Carry bit decides it
  assign add_shift = a[MANTISSA_SIZE+1] ? SHIFT_ONE : SHIFT_NONE;

  // Leading one search
  // Starts at the hidden bit, carry bit is never set here
  always_comb begin
    lead_shift = NO_ONE;
    found      = 1'b0;
    for (int i = MANTISSA_SIZE; i >= 0; i--) begin
      // First one wins, lower bits ignored
      if (!found && a[i]) begin
        lead_shift = SHIFT_MAX'(MANTISSA_SIZE - i);
        found      = 1'b1;
      end
    end
  end

  // Pick count by operation type
  assign shift = add ? add_shift : lead_shift;

endmodule

//--- design/operand_align.sv
`timescale 1ns/1ps
`include "fp_add_cfg.svh"

module operand_align (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  fp_add_pkg::fp_word_t a,
  input  fp_add_pkg::fp_word_t b,
  input  logic                 sub,
  output logic                 align_valid,
  output logic                 big_sign,
  output fp_add_pkg::exp_t     big_exp,
  output fp_add_pkg::mant_t    big_mant,
  output fp_add_pkg::mant_t    small_mant,
  output logic                 eff_sub
);

  localparam int FRAC_W   = `FP_MANTISSA_SIZE;
  localparam int EXP_W    = `FP_EXPONENT_SIZE;
  localparam int SIGN_BIT = FRAC_W + EXP_W;
  // Alignment past this many bits leaves nothing
  localparam fp_add_pkg::exp_t ALIGN_LIMIT = fp_add_pkg::exp_t'(FRAC_W + 2);

  // Unpacked operand a
  logic              a_sign;
  fp_add_pkg::exp_t  a_exp;
  fp_add_pkg::mant_t a_mant;

  // Unpacked operand b, sign already flipped for sub
  logic              b_sign;
  fp_add_pkg::exp_t  b_exp;
  fp_add_pkg::mant_t b_mant;

  // Swap decision and swapped operands
  logic              a_is_big;
  logic              big_sign_c;
  fp_add_pkg::exp_t  big_exp_c;
  fp_add_pkg::exp_t  small_exp_c;
  fp_add_pkg::mant_t big_mant_c;
  fp_add_pkg::mant_t small_mant_c;

  // Alignment
  fp_add_pkg::exp_t  exp_diff;
  fp_add_pkg::mant_t aligned_mant;

  // Field split of a
  assign a_sign = a[SIGN_BIT];
  assign a_exp  = a[SIGN_BIT-1:FRAC_W];
  // Zero exponent reads as zero, no subnormals
  assign a_mant = (a_exp == '0) ? '0 : {1'b0, 1'b1, a[FRAC_W-1:0]};

  // Field split of b
  // Subtraction is addition of negated b
  assign b_sign = b[SIGN_BIT] ^ sub;
  assign b_exp  = b[SIGN_BIT-1:FRAC_W];
  assign b_mant = (b_exp == '0) ? '0 : {1'b0, 1'b1, b[FRAC_W-1:0]};

  // Magnitude compare
  // Exponent first, then mantissa, full tie keeps a
  assign a_is_big = (a_exp > b_exp) || ((a_exp == b_exp) && (a_mant >= b_mant));

  // Larger operand goes first
  assign big_sign_c   = a_is_big ? a_sign : b_sign;
  assign big_exp_c    = a_is_big ? a_exp : b_exp;
  assign small_exp_c  = a_is_big ? b_exp : a_exp;
  assign big_mant_c   = a_is_big ? a_mant : b_mant;
  assign small_mant_c = a_is_big ? b_mant : a_mant;

  // Never negative, big exponent is the larger one
  assign exp_diff = big_exp_c - small_exp_c;

  // Right align smaller mantissa
  // Shifted out bits are dropped, truncation
  assign aligned_mant = (exp_diff >= ALIGN_LIMIT) ? '0 : (small_mant_c >> exp_diff);

  // Stage valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      align_valid <= 1'b0;
    end else begin
      align_valid <= in_valid;
    end
  end

  // Stage payload, only loaded on a new operation
  always_ff @(posedge clk) begin
    if (in_valid) begin
      big_sign   <= big_sign_c;
      big_exp    <= big_exp_c;
      big_mant   <= big_mant_c;
      small_mant <= aligned_mant;
      // Signs differ means magnitudes subtract
      eff_sub    <= a_sign ^ b_sign;
    end
  end

endmodule

//--- design/mantissa_addsub.sv
`timescale 1ns/1ps
`include "fp_add_cfg.svh"

module mantissa_addsub (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              align_valid,
  input  logic              big_sign,
  input  fp_add_pkg::exp_t  big_exp,
  input  fp_add_pkg::mant_t big_mant,
  input  fp_add_pkg::mant_t small_mant,
  input  logic              eff_sub,
  output logic              sum_valid,
  output logic              sum_sign,
  output fp_add_pkg::exp_t  sum_exp,
  output fp_add_pkg::mant_t sum_mant,
  output logic              sum_eff_sub
);

  // Extended mantissa width, carry bit included
  localparam int MANT_W = `FP_MANTISSA_SIZE + 2;

  // Raw magnitude sum
  fp_add_pkg::mant_t sum_c;

  // Operands enter with a clear carry bit
  // Addition lands any carry in the top bit
  // Subtraction never goes negative, big is the larger
  always_comb begin
    if (eff_sub) begin
      sum_c = big_mant - small_mant;
    end else begin
      sum_c = big_mant + small_mant;
    end
  end

  // Stage valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= align_valid;
    end
  end

  // Sum plus the fields the normalizer needs
  always_ff @(posedge clk) begin
    if (align_valid) begin
      // Result takes the sign of the larger magnitude
      sum_sign    <= big_sign;
      sum_exp     <= big_exp;
      sum_mant    <= sum_c[MANT_W-1:0];
      sum_eff_sub <= eff_sub;
    end
  end

endmodule

//--- design/result_normalize.sv
`timescale 1ns/1ps
`include "fp_add_cfg.svh"

module result_normalize (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sum_valid,
  input  logic                 sum_sign,
  input  fp_add_pkg::exp_t     sum_exp,
  input  fp_add_pkg::mant_t    sum_mant,
  input  logic                 sum_eff_sub,
  output logic                 out_valid,
  output fp_add_pkg::fp_word_t result
);

  localparam int FRAC_W = `FP_MANTISSA_SIZE;
  localparam int EXP_W  = `FP_EXPONENT_SIZE;
  localparam int MANT_W = FRAC_W + 2;
  // Two spare bits, one for the carry step, one for sign
  localparam int WIDE_W = EXP_W + 2;

  // Shift count from the leading one finder
  fp_add_pkg::shift_t              norm_shift;
  // Sum overflowed into the carry bit
  logic                            carry;
  // Mantissa with the leading one on the hidden bit
  fp_add_pkg::mant_t               norm_mant;
  // Exponent after the shift, may wrap below zero
  logic signed [WIDE_W-1:0]        exp_wide;
  // Packed word before the output register
  fp_add_pkg::fp_word_t            result_c;

  shift_amount #(
    .MANTISSA_SIZE(`FP_MANTISSA_SIZE),
    .SHIFT_MAX    (`FP_SHIFT_MAX)
  ) shift_amount_i (
    .a    (sum_mant),
    .add  (!sum_eff_sub),
    .shift(norm_shift)
  );

  // Only an effective addition can set it
  assign carry = sum_mant[MANT_W-1];

  // Normalization shift
  always_comb begin
    if (carry) begin
      // One step right, low bit dropped
      norm_mant = sum_mant >> 1;
      exp_wide  = $signed({2'b00, sum_exp}) + $signed(WIDE_W'(1));
    end else begin
      // Zero count for an addition without carry
      norm_mant = sum_mant << norm_shift;
      exp_wide  = $signed({2'b00, sum_exp}) - $signed(WIDE_W'(norm_shift));
    end
  end

  // Special cases, then packing
  always_comb begin
    if (sum_mant == '0) begin
      // Exact cancellation is always positive zero
      result_c = '0;
    end else if (exp_wide <= 0) begin
      // Flush to signed zero, no subnormal results
      result_c = {sum_sign, {(EXP_W + FRAC_W){1'b0}}};
    end else if (exp_wide >= `FP_EXP_MAX) begin
      // Signed infinity
      result_c = {sum_sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
    end else begin
      // Hidden bit dropped on packing
      result_c = {sum_sign, exp_wide[EXP_W-1:0], norm_mant[FRAC_W-1:0]};
    end
  end

  // Output valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  // Output word
  // Holds the last result between operations
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (sum_valid) begin
      result <= result_c;
    end
  end

endmodule

//--- design/fp_add_top.sv
`timescale 1ns/1ps
`include "fp_add_cfg.svh"

module fp_add_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  fp_add_pkg::fp_word_t a,
  input  fp_add_pkg::fp_word_t b,
  input  logic                 sub,
  output logic                 out_valid,
  output fp_add_pkg::fp_word_t result
);

  // Stage 1 to stage 2
  logic              align_valid;
  logic              big_sign;
  fp_add_pkg::exp_t  big_exp;
  fp_add_pkg::mant_t big_mant;
  fp_add_pkg::mant_t small_mant;
  logic              eff_sub;

  // Stage 2 to stage 3
  logic              sum_valid;
  logic              sum_sign;
  fp_add_pkg::exp_t  sum_exp;
  fp_add_pkg::mant_t sum_mant;
  logic              sum_eff_sub;

  // Unpack, compare, align
  operand_align align_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .a          (a),
    .b          (b),
    .sub        (sub),
    .align_valid(align_valid),
    .big_sign   (big_sign),
    .big_exp    (big_exp),
    .big_mant   (big_mant),
    .small_mant (small_mant),
    .eff_sub    (eff_sub)
  );

  // Magnitude add or subtract
  mantissa_addsub addsub_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .align_valid(align_valid),
    .big_sign   (big_sign),
    .big_exp    (big_exp),
    .big_mant   (big_mant),
    .small_mant (small_mant),
    .eff_sub    (eff_sub),
    .sum_valid  (sum_valid),
    .sum_sign   (sum_sign),
    .sum_exp    (sum_exp),
    .sum_mant   (sum_mant),
    .sum_eff_sub(sum_eff_sub)
  );

  // Normalize, range check, pack
  result_normalize normalize_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sum_valid  (sum_valid),
    .sum_sign   (sum_sign),
    .sum_exp    (sum_exp),
    .sum_mant   (sum_mant),
    .sum_eff_sub(sum_eff_sub),
    .out_valid  (out_valid),
    .result     (result)
  );

endmodule

//--- tb/tb_fp_add_top.sv
`timescale 1ns/1ps
`include "fp_add_cfg.svh"

module tb_fp_add_top;

  // Phase lengths in clock slots
  localparam int N_QUIET  = 4;
  localparam int N_STREAM = 500;
  localparam int N_ADD    = 300;
  localparam int N_SUB    = 300;
  localparam int N_ZERO   = 48;
  localparam int N_RANGE  = 100;
  localparam int N_GAP    = 200;
  localparam int N_TOTAL  = N_QUIET + N_STREAM + N_ADD + N_SUB + N_ZERO + N_RANGE + N_GAP;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT  = N_TOTAL + RESET_CYCLES + 64;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  fp_add_pkg::fp_word_t a;
  fp_add_pkg::fp_word_t b;
  logic                 sub;
  logic                 out_valid;
  fp_add_pkg::fp_word_t result;

  // Outstanding operations with the oldest first
  fp_add_pkg::fp_word_t exp_q[$];
  fp_add_pkg::fp_word_t a_q[$];
  fp_add_pkg::fp_word_t b_q[$];
  logic                 sub_q[$];
  int                   issue_q[$];

  int          cycle_cnt = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;
  logic [31:0] lfsr_state = 32'd57103;

  fp_add_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .sub      (sub),
    .out_valid(out_valid),
    .result   (result)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // One Galois step
  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(rand_bits(16) % (hi - lo + 1));
  endfunction

  function automatic fp_add_pkg::fp_word_t make_word(input logic s, input int e,
                                                     input logic [63:0] frac);
    return {s, 11'(e), frac[51:0]};
  endfunction

  // Normal operand with an exponent never zero or all ones
  function automatic fp_add_pkg::fp_word_t rand_normal();
    return make_word(rand_bits(1), rand_range(1, 2046), rand_bits(52));
  endfunction

  // Any operand the DUT accepts including a zero exponent
  function automatic fp_add_pkg::fp_word_t rand_word();
    return make_word(rand_bits(1), rand_range(0, 2046), rand_bits(52));
  endfunction

  // Reference add with magnitudes held as plain integers
  function automatic fp_add_pkg::fp_word_t model_add(input fp_add_pkg::fp_word_t x,
                                                     input fp_add_pkg::fp_word_t y,
                                                     input logic op_sub);
    logic                 sign_x, sign_y, sign_r;
    int                   exp_x, exp_y, exp_r, diff;
    longint unsigned      man_x, man_y, man_big, man_small, mag;
    fp_add_pkg::fp_word_t w;
    sign_x = x[63];
    sign_y = y[63] ^ op_sub;
    exp_x  = int'(x[62:52]);
    exp_y  = int'(y[62:52]);
    // Zero field means zero value
    man_x  = (exp_x == 0) ? 64'd0 : ((64'd1 << 52) | x[51:0]);
    man_y  = (exp_y == 0) ? 64'd0 : ((64'd1 << 52) | y[51:0]);
    if (exp_x > exp_y || (exp_x == exp_y && man_x >= man_y)) begin
      sign_r = sign_x;
      exp_r = exp_x;
      man_big = man_x;
      man_small = man_y;
      diff = exp_x - exp_y;
    end else begin
      sign_r = sign_y;
      exp_r = exp_y;
      man_big = man_y;
      man_small = man_x;
      diff = exp_y - exp_x;
    end
    man_small = (diff >= 54) ? 64'd0 : (man_small >> diff);
    mag = (sign_x != sign_y) ? (man_big - man_small) : (man_big + man_small);
    if (mag >= (64'd1 << 53)) begin
      mag = mag >> 1;
      exp_r = exp_r + 1;
    end else if (mag != 0) begin
      // Walk the leading one up to the hidden position
      while (mag < (64'd1 << 52)) begin
        mag = mag << 1;
        exp_r = exp_r - 1;
      end
    end
    if (mag == 0) w = '0;
    else if (exp_r <= 0) w = {sign_r, 63'd0};
    else if (exp_r >= `FP_EXP_MAX) w = {sign_r, 11'h7ff, 52'd0};
    else w = {sign_r, 11'(exp_r), mag[51:0]};
    return w;
  endfunction

  task automatic check_word(input fp_add_pkg::fp_word_t exp_w, input fp_add_pkg::fp_word_t act_w,
                            input fp_add_pkg::fp_word_t op_a, input fp_add_pkg::fp_word_t op_b,
                            input logic op_sub);
    if (act_w !== exp_w) begin
      value_errors++;
      $display("Fail at %0t: a=%h b=%h sub=%0d expected %h got %h",
               $time, op_a, op_b, op_sub, exp_w, act_w);
    end
  endtask

  task automatic check_latency(input int exp_l, input int act_l);
    if (act_l != exp_l) begin
      value_errors++;
      $display("Fail at %0t: latency expected %0d cycles got %0d", $time, exp_l, act_l);
    end
  endtask

  // Inputs change on the falling edge and are captured on the next rising edge
  task automatic drive_op(input fp_add_pkg::fp_word_t op_a, input fp_add_pkg::fp_word_t op_b,
                          input logic op_sub);
    @(negedge clk);
    in_valid = 1'b1;
    a = op_a;
    b = op_b;
    sub = op_sub;
    exp_q.push_back(model_add(op_a, op_b, op_sub));
    a_q.push_back(op_a);
    b_q.push_back(op_b);
    sub_q.push_back(op_sub);
    // Latency counts from the cycle the operands are presented
    issue_q.push_back(cycle_cnt);
  endtask

  task automatic drive_idle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // Two operands whose fractions agree above bit k
  task automatic drive_close_pair(input int ea, input int d, input logic op_sub);
    logic        s;
    logic [63:0] fa, fb, mask;
    int          k, eb;
    s    = rand_bits(1);
    k    = rand_range(0, 52);
    mask = (64'd1 << k) - 1;
    fa   = rand_bits(52);
    fb   = (d == 0) ? ((fa & ~mask) | (rand_bits(52) & mask)) : rand_bits(52);
    eb   = (ea > d) ? ea - d : ea + d;
    // Effective b sign is the opposite of a
    drive_op(make_word(s, ea, fa), make_word(s ^ op_sub ^ 1'b1, eb, fb), op_sub);
  endtask

  // Same effective sign on both operands
  task automatic drive_same_sign(input int ea, input int eb);
    logic s, op;
    s  = rand_bits(1);
    op = rand_bits(1);
    drive_op(make_word(s, ea, rand_bits(52)), make_word(s ^ op, eb, rand_bits(52)), op);
  endtask

  // Results sampled away from the rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (out_valid) begin
        protocol_errors++;
        $display("out_valid went high while reset was held, time %0t", $time);
      end
    end else if (out_valid) begin
      if (exp_q.size() == 0) begin
        protocol_errors++;
        $display("out_valid pulsed with no operation outstanding, time %0t", $time);
      end else begin
        check_word(exp_q.pop_front(), result, a_q.pop_front(), b_q.pop_front(),
                   sub_q.pop_front());
        check_latency(3, cycle_cnt - issue_q.pop_front());
      end
    end
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped by timeout after %0d cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    int ea, d, drain_cnt;
    fp_add_pkg::fp_word_t w;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    sub      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet cycles right after reset
    repeat (N_QUIET) drive_idle();

    // Back to back random stream
    repeat (N_STREAM) drive_op(rand_word(), rand_word(), rand_bits(1));

    // Effective additions with gaps up to 63
    repeat (N_ADD) begin
      ea = rand_range(1, 2046);
      d  = rand_range(0, 63);
      drive_same_sign(ea, (ea > d) ? ea - d : ea + d);
    end

    // Exact self cancellation first
    repeat (4) begin
      w = rand_normal();
      drive_op(w, w, 1'b1);
    end
    // Near cancellation with the leading one anywhere
    repeat (N_SUB - 4) begin
      drive_close_pair(rand_range(1, 2046), rand_range(0, 2), rand_bits(1));
    end

    // Zero field on a, on b, then on both
    for (int pat = 0; pat < 3; pat++) begin
      repeat (N_ZERO / 3) begin
        drive_op((pat != 1) ? make_word(rand_bits(1), 0, rand_bits(52)) : rand_normal(),
                 (pat != 0) ? make_word(rand_bits(1), 0, rand_bits(52)) : rand_normal(),
                 rand_bits(1));
      end
    end

    // Overflow to infinity near the top exponent
    repeat (N_RANGE / 2) drive_same_sign(rand_range(2040, 2046), rand_range(2040, 2046));
    // Cancellation below the smallest exponent
    repeat (N_RANGE / 2) drive_close_pair(rand_range(1, 3), rand_range(0, 1), rand_bits(1));

    // Random idle slots mixed in
    repeat (N_GAP) begin
      if (rand_bits(1)) drive_op(rand_word(), rand_word(), rand_bits(1));
      else drive_idle();
    end

    // Drain and then watch for stray pulses
    drain_cnt = 0;
    while (exp_q.size() != 0 && drain_cnt < 16) begin
      drive_idle();
      drain_cnt++;
    end
    repeat (8) drive_idle();
    if (exp_q.size() != 0) begin
      protocol_errors++;
      $display("%0d operations never produced a result", exp_q.size());
    end

    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+design
design/fp_add_pkg.sv
design/shift_amount.sv
design/operand_align.sv
design/mantissa_addsub.sv
design/result_normalize.sv
design/fp_add_top.sv
tb/tb_fp_add_top.sv
